// ==== files.f ====
+incdir+logic
logic/exec_types_pkg.sv
logic/mmu_prot_pkg.sv
logic/mmu_flag_table.sv
logic/execute_exception_check_ldst.sv
logic/execute_ldst_ctrl.sv
logic/ldst_data_ram.sv
logic/execute_ldst_top.sv
tb/tb_execute_ldst.sv

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/10ps \
	--top-module tb_execute_ldst -f files.f

out=$(./obj_dir/Vtb_execute_ldst 2>&1) || true
printf '%s\n' "$out"

if printf '%s\n' "$out" | grep -qx 'TEST PASS'; then
	exit 0
fi
exit 1

// ==== tb/tb_execute_ldst.sv ====
`timescale 1ns/10ps

`include "ldst_defines.svh"

module tb_execute_ldst
	import exec_types_pkg::*;
	import mmu_prot_pkg::*;
();

	localparam int CLK_PERIOD    = 8;
	localparam int RESET_CYCLES  = 5;
	localparam int MAX_STALL     = 4;
	localparam int ROW_LATENCY   = 3;
	// Request, accept and idle-check edges around each row
	localparam int ROW_HANDSHAKE = 5;
	localparam int ROW_BOUND     = ROW_LATENCY + MAX_STALL + ROW_HANDSHAKE;
	localparam int SETUP_CYCLES  = RESET_CYCLES + 20;
	localparam int FLUSH_QUIET   = 4;

	// Allowed accesses per privilege field, bit index is the field value
	localparam bit [3:0] USER_LOAD_OK    = 4'b1110;
	localparam bit [3:0] USER_STORE_OK   = 4'b1000;
	localparam bit [3:0] KERNEL_STORE_OK = 4'b1101;

	typedef struct packed {
		ldst_op_t                op;
		logic [`LDST_ADDR_W-1:0] addr;
		logic [`LDST_DATA_W-1:0] wdata;
		logic                    kernel;
		logic                    paging;
		logic                    flush_mid;
		logic                    exp_except;
		logic [`LDST_DATA_W-1:0] exp_rdata;
	} row_t;

	logic                       iCLOCK = 1'b0;
	logic                       inRESET;
	logic                       flush;
	logic                       req_valid;
	ldst_op_t                   req_op;
	logic [`LDST_ADDR_W-1:0]    req_addr;
	logic [`LDST_DATA_W-1:0]    req_wdata;
	logic                       req_kernel;
	logic                       req_paging;
	logic                       req_ready;
	logic                       resp_valid;
	logic                       resp_except;
	except_num_t                resp_except_num;
	logic [`LDST_DATA_W-1:0]    resp_rdata;
	logic                       resp_ready;
	logic                       cfg_we;
	logic [`LDST_PAGE_BITS-1:0] cfg_page;
	logic [`MMU_FLAG_W-1:0]     cfg_flags;

	row_t                    rows[$];
	priv_field_t             page_priv [`LDST_PAGE_NUM] = '{default: PRIV_KERNEL_ONLY};
	logic [`LDST_DATA_W-1:0] model_mem [`LDST_RAM_DEPTH] = '{default: '0};
	bit                      table_ready = 1'b0;
	int                      stall_run = 0;
	int                      resp_count = 0;
	int                      exp_resp_count = 0;

	always #(CLK_PERIOD / 2) iCLOCK = ~iCLOCK;

	execute_ldst_top u_dut (
		.iCLOCK          (iCLOCK),
		.inRESET         (inRESET),
		.flush           (flush),
		.req_valid       (req_valid),
		.req_op          (req_op),
		.req_addr        (req_addr),
		.req_wdata       (req_wdata),
		.req_kernel      (req_kernel),
		.req_paging      (req_paging),
		.req_ready       (req_ready),
		.resp_valid      (resp_valid),
		.resp_except     (resp_except),
		.resp_except_num (resp_except_num),
		.resp_rdata      (resp_rdata),
		.resp_ready      (resp_ready),
		.cfg_we          (cfg_we),
		.cfg_page        (cfg_page),
		.cfg_flags       (cfg_flags)
	);

	// Response handshakes seen on the bus, whatever row is running
	always @(negedge iCLOCK) begin
		if (inRESET && resp_valid && resp_ready) begin
			resp_count++;
		end
	end

	task automatic report_mismatch(input string what);
		$display("CHECK FAILED at %0d ns: %s", $time, what);
		$display("TEST FAIL");
		$fatal(1);
	endtask

	task automatic report_failure(input string what);
		$display("Protocol error at %0d ns: %s", $time, what);
		$display("TEST FAIL");
		$fatal(1);
	endtask

	function automatic logic expect_fault(input logic kernel, input logic paging,
	                                      input ldst_op_t op, input priv_field_t field);
		logic ok;
		if (!paging)
			ok = 1'b1;
		else if (op == LDST_OP_LOAD)
			ok = kernel || USER_LOAD_OK[field];
		else if (kernel)
			ok = KERNEL_STORE_OK[field];
		else
			ok = USER_STORE_OK[field];
		return !ok;
	endfunction

	function automatic logic [`MMU_FLAG_W-1:0] flag_word(input priv_field_t priv);
		logic [`MMU_FLAG_W-1:0] w;
		w = '0;
		// Unrelated attribute bit, must not affect the check
		w[0] = 1'b1;
		w[`MMU_PRIV_LSB +: 2] = priv;
		return w;
	endfunction

	// Expected values come from the page setup and the model memory
	task automatic add_row(input ldst_op_t op, input logic [`LDST_ADDR_W-1:0] addr,
	                       input logic [`LDST_DATA_W-1:0] wdata, input logic kernel,
	                       input logic paging, input logic flush_mid);
		row_t                    r;
		logic [`LDST_RAM_AW-1:0] word;
		word = addr[`LDST_RAM_AW+1:2];
		r.op = op;
		r.addr = addr;
		r.wdata = wdata;
		r.kernel = kernel;
		r.paging = paging;
		r.flush_mid = flush_mid;
		r.exp_except = expect_fault(kernel, paging, op,
			page_priv[addr[`LDST_ADDR_W-1 -: `LDST_PAGE_BITS]]);
		r.exp_rdata = (!r.exp_except && op == LDST_OP_LOAD) ? model_mem[word] : '0;
		if (!flush_mid && !r.exp_except && op == LDST_OP_STORE)
			model_mem[word] = wdata;
		if (!flush_mid)
			exp_resp_count++;
		rows.push_back(r);
	endtask

	task automatic build_table();
		add_row(LDST_OP_STORE, 16'h3010, 32'hA5A5_0001, 1'b1, 1'b1, 1'b0);
		add_row(LDST_OP_LOAD,  16'h3010, 32'h0,         1'b1, 1'b1, 1'b0);
		// User mode across every field and op
		add_row(LDST_OP_STORE, 16'h0020, 32'h1111_0002, 1'b0, 1'b1, 1'b0);
		add_row(LDST_OP_LOAD,  16'h0020, 32'h0,         1'b0, 1'b1, 1'b0);
		add_row(LDST_OP_STORE, 16'h1024, 32'h2222_0003, 1'b0, 1'b1, 1'b0);
		add_row(LDST_OP_LOAD,  16'h1024, 32'h0,         1'b0, 1'b1, 1'b0);
		add_row(LDST_OP_STORE, 16'h2028, 32'h3333_0004, 1'b0, 1'b1, 1'b0);
		add_row(LDST_OP_LOAD,  16'h2028, 32'h0,         1'b0, 1'b1, 1'b0);
		add_row(LDST_OP_STORE, 16'h3030, 32'h4444_0005, 1'b0, 1'b1, 1'b0);
		add_row(LDST_OP_LOAD,  16'h3030, 32'h0,         1'b0, 1'b1, 1'b0);
		add_row(LDST_OP_STORE, 16'h1040, 32'h5555_0006, 1'b1, 1'b1, 1'b0);
		add_row(LDST_OP_STORE, 16'h0044, 32'h6666_0007, 1'b1, 1'b1, 1'b0);
		add_row(LDST_OP_STORE, 16'h2048, 32'h7777_0008, 1'b1, 1'b1, 1'b0);
		add_row(LDST_OP_LOAD,  16'h0044, 32'h0,         1'b1, 1'b1, 1'b0);
		// Faulting store must leave the old word in place
		add_row(LDST_OP_STORE, 16'h0044, 32'hDEAD_BEEF, 1'b0, 1'b1, 1'b0);
		add_row(LDST_OP_LOAD,  16'h0044, 32'h0,         1'b1, 1'b1, 1'b0);
		// Paging off
		add_row(LDST_OP_STORE, 16'h0050, 32'h8888_0009, 1'b0, 1'b0, 1'b0);
		add_row(LDST_OP_LOAD,  16'h0050, 32'h0,         1'b0, 1'b0, 1'b0);
		add_row(LDST_OP_STORE, 16'h1054, 32'h9999_000A, 1'b1, 1'b0, 1'b0);
		add_row(LDST_OP_LOAD,  16'h1054, 32'h0,         1'b0, 1'b0, 1'b0);
		// Flushed store, then the row after it
		add_row(LDST_OP_STORE, 16'h3060, 32'hCAFE_000B, 1'b0, 1'b1, 1'b1);
		add_row(LDST_OP_LOAD,  16'h3060, 32'h0,         1'b0, 1'b1, 1'b0);
		add_row(LDST_OP_LOAD,  16'h2048, 32'h0,         1'b1, 1'b1, 1'b0);
		add_row(LDST_OP_STORE, 16'h2048, 32'hBAD0_000C, 1'b0, 1'b1, 1'b0);
		add_row(LDST_OP_LOAD,  16'h2048, 32'h0,         1'b0, 1'b1, 1'b0);
	endtask

	task automatic write_page_flags(input logic [`LDST_PAGE_BITS-1:0] page,
	                                input priv_field_t priv);
		@(posedge iCLOCK);
		cfg_we <= 1'b1;
		cfg_page <= page;
		cfg_flags <= flag_word(priv);
		@(posedge iCLOCK);
		cfg_we <= 1'b0;
	endtask

	// Random stalls, never longer than MAX_STALL cycles in a row
	task automatic drive_resp_ready();
		if (stall_run >= MAX_STALL || $urandom_range(3, 0) >= 2) begin
			resp_ready <= 1'b1;
			stall_run = 0;
		end
		else begin
			resp_ready <= 1'b0;
			stall_run++;
		end
	endtask

	task automatic run_row(input int idx);
		row_t                    r;
		time                     t_accept;
		int                      latency;
		int                      exp_latency;
		except_num_t             exp_num;
		logic                    seen;
		logic                    accepted;
		logic                    held_except;
		except_num_t             held_num;
		logic [`LDST_DATA_W-1:0] held_rdata;
		r = rows[idx];
		exp_latency = r.exp_except ? 2 : 3;
		exp_num = r.exp_except ? EXC_PRIVILEGE : EXC_NONE;
		@(posedge iCLOCK);
		req_valid <= 1'b1;
		req_op <= r.op;
		req_addr <= r.addr;
		req_wdata <= r.wdata;
		req_kernel <= r.kernel;
		req_paging <= r.paging;
		@(negedge iCLOCK);
		while (!req_ready) begin
			@(negedge iCLOCK);
		end
		// Handshake edge
		@(posedge iCLOCK);
		t_accept = $time;
		req_valid <= 1'b0;
		if (r.flush_mid) begin
			// Flush lands in the lookup cycle
			flush <= 1'b1;
			@(posedge iCLOCK);
			flush <= 1'b0;
			repeat (FLUSH_QUIET) begin
				@(negedge iCLOCK);
				assert (!resp_valid)
					else report_failure($sformatf("row %0d flushed but responded", idx));
				assert (req_ready)
					else report_failure($sformatf("row %0d req_ready low after flush", idx));
			end
			return;
		end
		seen = 1'b0;
		accepted = 1'b0;
		while (!accepted) begin
			@(negedge iCLOCK);
			if (resp_valid) begin
				if (!seen) begin
					latency = int'(($time - t_accept) / CLK_PERIOD);
					assert (latency == exp_latency)
						else report_mismatch($sformatf("row %0d latency %0d expected %0d",
							idx, latency, exp_latency));
					assert (resp_except == r.exp_except)
						else report_mismatch($sformatf("row %0d except %b expected %b",
							idx, resp_except, r.exp_except));
					assert (resp_except_num == exp_num)
						else report_mismatch($sformatf("row %0d except_num %h expected %h",
							idx, resp_except_num, exp_num));
					assert (resp_rdata == r.exp_rdata)
						else report_mismatch($sformatf("row %0d rdata %h expected %h",
							idx, resp_rdata, r.exp_rdata));
					held_except = resp_except;
					held_num = resp_except_num;
					held_rdata = resp_rdata;
					seen = 1'b1;
				end
				else begin
					assert (resp_except == held_except && resp_except_num == held_num
						&& resp_rdata == held_rdata)
						else report_mismatch($sformatf("row %0d response changed while stalled",
							idx));
				end
				assert (!req_ready)
					else report_failure($sformatf("row %0d req_ready high during response", idx));
				accepted = resp_ready;
			end
			else begin
				assert (!seen)
					else report_failure($sformatf("row %0d response dropped before accept", idx));
			end
			@(posedge iCLOCK);
			drive_resp_ready();
		end
		@(negedge iCLOCK);
		assert (!resp_valid)
			else report_failure($sformatf("row %0d response presented twice", idx));
		assert (req_ready)
			else report_failure($sformatf("row %0d req_ready low after accept", idx));
	endtask

	initial begin : watchdog
		int limit;
		wait (table_ready);
		limit = (SETUP_CYCLES + rows.size() * ROW_BOUND) * CLK_PERIOD;
		#(limit);
		$display("TEST FAIL");
		$display("Simulation timed out before all rows completed");
		$fatal(1);
	end

	initial begin
		void'($urandom(44900));
		inRESET <= 1'b0;
		flush <= 1'b0;
		req_valid <= 1'b0;
		req_op <= LDST_OP_LOAD;
		req_addr <= '0;
		req_wdata <= '0;
		req_kernel <= 1'b0;
		req_paging <= 1'b0;
		resp_ready <= 1'b1;
		cfg_we <= 1'b0;
		cfg_page <= '0;
		cfg_flags <= '0;
		page_priv[1] = PRIV_ALL_RO;
		page_priv[2] = PRIV_KERNEL_RW_USER_RO;
		page_priv[3] = PRIV_ALL_RW;
		build_table();
		table_ready = 1'b1;
		repeat (RESET_CYCLES) @(posedge iCLOCK);
		inRESET <= 1'b1;
		@(negedge iCLOCK);
		assert (req_ready && !resp_valid)
			else report_failure("controller not idle after reset");
		for (int p = 0; p < 4; p++) begin
			write_page_flags(p[`LDST_PAGE_BITS-1:0], page_priv[p]);
		end
		for (int i = 0; i < rows.size(); i++) begin
			run_row(i);
		end
		assert (resp_count == exp_resp_count)
			else report_failure($sformatf("%0d responses seen, %0d expected",
				resp_count, exp_resp_count));
		@(posedge iCLOCK);
		$display("TEST PASS");
		$finish;
	end

endmodule

// ==== logic/execute_ldst_top.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "ldst_defines.svh"

module execute_ldst_top
	import exec_types_pkg::*;
	import mmu_prot_pkg::*;
(
	input  wire                          iCLOCK,
	input  wire                          inRESET,
	input  wire                          flush,
	// Request channel
	input  wire                          req_valid,
	input  ldst_op_t                     req_op,
	input  wire [`LDST_ADDR_W-1:0]       req_addr,
	input  wire [`LDST_DATA_W-1:0]       req_wdata,
	input  wire                          req_kernel,
	input  wire                          req_paging,
	output logic                         req_ready,
	// Response channel
	output logic                         resp_valid,
	output logic                         resp_except,
	output except_num_t                  resp_except_num,
	output logic [`LDST_DATA_W-1:0]      resp_rdata,
	input  wire                          resp_ready,
	// Page flag configuration
	input  wire                          cfg_we,
	input  wire [`LDST_PAGE_BITS-1:0]    cfg_page,
	input  wire [`MMU_FLAG_W-1:0]        cfg_flags
);

	exec_state_t                state;
	logic                       accept;
	logic                       lookup_en;
	logic [`LDST_PAGE_BITS-1:0] lookup_page;
	logic [`MMU_FLAG_W-1:0]     lookup_flags;
	logic                       except_valid;
	except_num_t                except_num;
	logic                       ram_en;
	logic                       ram_we;
	logic [`LDST_RAM_AW-1:0]    ram_addr;
	logic [`LDST_DATA_W-1:0]    ram_wdata;
	logic [`LDST_DATA_W-1:0]    ram_rdata;

	execute_ldst_ctrl u_ctrl (
		.iCLOCK          (iCLOCK),
		.inRESET         (inRESET),
		.flush           (flush),
		.req_valid       (req_valid),
		.req_op          (req_op),
		.req_addr        (req_addr),
		.req_wdata       (req_wdata),
		.req_ready       (req_ready),
		.resp_valid      (resp_valid),
		.resp_except     (resp_except),
		.resp_except_num (resp_except_num),
		.resp_rdata      (resp_rdata),
		.resp_ready      (resp_ready),
		.state           (state),
		.accept          (accept),
		.except_valid    (except_valid),
		.except_num      (except_num),
		.lookup_en       (lookup_en),
		.lookup_page     (lookup_page),
		.ram_en          (ram_en),
		.ram_we          (ram_we),
		.ram_addr        (ram_addr),
		.ram_wdata       (ram_wdata),
		.ram_rdata       (ram_rdata)
	);

	mmu_flag_table u_flag_table (
		.iCLOCK       (iCLOCK),
		.inRESET      (inRESET),
		.cfg_we       (cfg_we),
		.cfg_page     (cfg_page),
		.cfg_flags    (cfg_flags),
		.lookup_en    (lookup_en),
		.lookup_page  (lookup_page),
		.lookup_flags (lookup_flags)
	);

	// Privilege context goes straight from the request to the checker
	execute_exception_check_ldst u_except_check (
		.iCLOCK       (iCLOCK),
		.inRESET      (inRESET),
		.flush        (flush),
		.state        (state),
		.accept       (accept),
		.kernel       (req_kernel),
		.paging       (req_paging),
		.op           (req_op),
		.mmu_flags    (lookup_flags),
		.except_valid (except_valid),
		.except_num   (except_num)
	);

	ldst_data_ram u_data_ram (
		.iCLOCK    (iCLOCK),
		.inRESET   (inRESET),
		.ram_en    (ram_en),
		.ram_we    (ram_we),
		.ram_addr  (ram_addr),
		.ram_wdata (ram_wdata),
		.ram_rdata (ram_rdata)
	);

endmodule

`default_nettype wire

// ==== logic/ldst_data_ram.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "ldst_defines.svh"

module ldst_data_ram (
	input  wire                      iCLOCK,
	input  wire                      inRESET,
	input  wire                      ram_en,
	input  wire                      ram_we,
	input  wire [`LDST_RAM_AW-1:0]   ram_addr,
	input  wire [`LDST_DATA_W-1:0]   ram_wdata,
	output logic [`LDST_DATA_W-1:0]  ram_rdata
);

	logic [`LDST_DATA_W-1:0] mem [`LDST_RAM_DEPTH];

	// Write completes at the edge
	always_ff @(posedge iCLOCK or negedge inRESET) begin
		if (!inRESET) begin
			for (int i = 0; i < `LDST_RAM_DEPTH; i++) begin
				mem[i] <= '0;
			end
		end
		else if (ram_en && ram_we) begin
			mem[ram_addr] <= ram_wdata;
		end
	end

	// One-cycle registered read
	always_ff @(posedge iCLOCK or negedge inRESET) begin
		if (!inRESET) begin
			ram_rdata <= '0;
		end
		else if (ram_en && !ram_we) begin
			ram_rdata <= mem[ram_addr];
		end
	end

endmodule

`default_nettype wire

// ==== logic/execute_ldst_ctrl.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "ldst_defines.svh"

module execute_ldst_ctrl
	import exec_types_pkg::*;
	import mmu_prot_pkg::*;
(
	input  wire                          iCLOCK,
	input  wire                          inRESET,
	input  wire                          flush,
	// Request channel
	input  wire                          req_valid,
	input  ldst_op_t                     req_op,
	input  wire [`LDST_ADDR_W-1:0]       req_addr,
	input  wire [`LDST_DATA_W-1:0]       req_wdata,
	output logic                         req_ready,
	// Response channel
	output logic                         resp_valid,
	output logic                         resp_except,
	output except_num_t                  resp_except_num,
	output logic [`LDST_DATA_W-1:0]      resp_rdata,
	input  wire                          resp_ready,
	// Checker side
	output exec_state_t                  state,
	output logic                         accept,
	input  wire                          except_valid,
	input  except_num_t                  except_num,
	// Flag table lookup
	output logic                         lookup_en,
	output logic [`LDST_PAGE_BITS-1:0]   lookup_page,
	// Data RAM
	output logic                         ram_en,
	output logic                         ram_we,
	output logic [`LDST_RAM_AW-1:0]      ram_addr,
	output logic [`LDST_DATA_W-1:0]      ram_wdata,
	input  wire [`LDST_DATA_W-1:0]       ram_rdata
);

	ldst_op_t                op_q;
	logic [`LDST_RAM_AW-1:0] word_q;
	logic [`LDST_DATA_W-1:0] wdata_q;
	logic                    exc_q;
	except_num_t             exc_num_q;
	logic                    resp_capture;

	assign req_ready    = (state == EXEC_IDLE);
	assign accept       = req_valid && req_ready;
	// Table lookup is started on the accept edge itself
	assign lookup_en    = accept;
	assign lookup_page  = req_addr[`LDST_ADDR_W-1 -: `LDST_PAGE_BITS];
	// First RESP cycle, before the response is presented
	assign resp_capture = (state == EXEC_RESP) && !resp_valid;

	always_ff @(posedge iCLOCK or negedge inRESET) begin
		if (!inRESET) begin
			state      <= EXEC_IDLE;
			op_q       <= LDST_OP_LOAD;
			exc_q      <= 1'b0;
			exc_num_q  <= EXC_NONE;
			resp_valid <= 1'b0;
		end
		else if (flush) begin
			state      <= EXEC_IDLE;
			exc_q      <= 1'b0;
			exc_num_q  <= EXC_NONE;
			resp_valid <= 1'b0;
		end
		else begin
			case (state)
				EXEC_IDLE: begin
					if (accept) begin
						op_q  <= req_op;
						exc_q <= 1'b0;
						state <= EXEC_LOOKUP;
					end
				end
				EXEC_LOOKUP: begin
					exc_q     <= except_valid;
					exc_num_q <= except_num;
					state     <= except_valid ? EXEC_RESP : EXEC_ACCESS;
				end
				EXEC_ACCESS: begin
					state <= EXEC_RESP;
				end
				EXEC_RESP: begin
					if (resp_capture) begin
						resp_valid <= 1'b1;
					end
					else if (resp_ready) begin
						resp_valid <= 1'b0;
						state      <= EXEC_IDLE;
					end
				end
				default: state <= EXEC_IDLE;
			endcase
		end
	end

	// Request payload
	always_ff @(posedge iCLOCK) begin
		if (accept) begin
			word_q  <= req_addr[`LDST_RAM_AW+1:2];
			wdata_q <= req_wdata;
		end
	end

	// Response payload, read data is zero for stores and exceptions
	always_ff @(posedge iCLOCK) begin
		if (resp_capture) begin
			resp_except     <= exc_q;
			resp_except_num <= exc_num_q;
			resp_rdata      <= (exc_q || op_q == LDST_OP_STORE) ? '0 : ram_rdata;
		end
	end

	assign ram_en    = (state == EXEC_ACCESS);
	assign ram_we    = ram_en && (op_q == LDST_OP_STORE);
	assign ram_addr  = word_q;
	assign ram_wdata = wdata_q;

	a_resp_stable: assert property (
		@(posedge iCLOCK) disable iff (!inRESET || flush)
		(resp_valid && !resp_ready) |=> resp_valid && $stable(resp_except)
			&& $stable(resp_except_num) && $stable(resp_rdata)
	);

	// RAM is only touched after a lookup that passed the privilege check
	a_ram_after_check: assert property (
		@(posedge iCLOCK) disable iff (!inRESET)
		ram_en |-> (state == EXEC_ACCESS) && ($past(state) == EXEC_LOOKUP)
			&& !$past(except_valid)
	);

endmodule

`default_nettype wire

// ==== logic/execute_exception_check_ldst.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "ldst_defines.svh"

module execute_exception_check_ldst
	import exec_types_pkg::*;
	import mmu_prot_pkg::*;
(
	input  wire                    iCLOCK,
	input  wire                    inRESET,
	input  wire                    flush,
	// Controller state and request accept strobe
	input  exec_state_t            state,
	input  wire                    accept,
	// Privilege context of the request
	input  wire                    kernel,
	input  wire                    paging,
	input  ldst_op_t               op,
	// Flags of the accessed page
	input  wire [`MMU_FLAG_W-1:0]  mmu_flags,
	output logic                   except_valid,
	output except_num_t            except_num
);

	logic        kernel_q;
	logic        paging_q;
	ldst_op_t    op_q;
	priv_field_t priv_field;
	logic        priv_error;

	// Context is captured once, at the request handshake
	always_ff @(posedge iCLOCK or negedge inRESET) begin
		if (!inRESET) begin
			kernel_q <= 1'b0;
			paging_q <= 1'b0;
			op_q     <= LDST_OP_LOAD;
		end
		else if (flush) begin
			kernel_q <= 1'b0;
			paging_q <= 1'b0;
			op_q     <= LDST_OP_LOAD;
		end
		else if (accept) begin
			kernel_q <= kernel;
			paging_q <= paging;
			op_q     <= op;
		end
	end

	function automatic logic priv_check(input logic is_kernel, input logic is_store,
	                                    input priv_field_t field);
		logic err;
		err = 1'b0;
		if (is_kernel) begin
			// Kernel only trips on a read-only page
			err = (field == PRIV_ALL_RO) && is_store;
		end
		else begin
			case (field)
				PRIV_KERNEL_ONLY:       err = 1'b1;
				PRIV_ALL_RO,
				PRIV_KERNEL_RW_USER_RO: err = is_store;
				default:                err = 1'b0;
			endcase
		end
		return err;
	endfunction

	assign priv_field = priv_field_t'(mmu_flags[`MMU_PRIV_LSB +: 2]);
	assign priv_error = paging_q && priv_check(kernel_q, op_q == LDST_OP_STORE, priv_field);

	// Flags are only meaningful while the lookup result is on the bus
	assign except_valid = priv_error && (state == EXEC_LOOKUP);
	assign except_num   = except_valid ? EXC_PRIVILEGE : EXC_NONE;

	// A reported exception must steer the controller straight to the response
	a_except_to_resp: assert property (
		@(posedge iCLOCK) disable iff (!inRESET || flush)
		except_valid |-> (except_num == EXC_PRIVILEGE) ##1 (state == EXEC_RESP)
	);

endmodule

`default_nettype wire

// ==== logic/mmu_flag_table.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "ldst_defines.svh"

module mmu_flag_table (
	input  wire                        iCLOCK,
	input  wire                        inRESET,
	// Configuration write port
	input  wire                        cfg_we,
	input  wire [`LDST_PAGE_BITS-1:0]  cfg_page,
	input  wire [`MMU_FLAG_W-1:0]      cfg_flags,
	// Lookup port
	input  wire                        lookup_en,
	input  wire [`LDST_PAGE_BITS-1:0]  lookup_page,
	output logic [`MMU_FLAG_W-1:0]     lookup_flags
);

	logic [`MMU_FLAG_W-1:0] flags [`LDST_PAGE_NUM];

	// All pages start out kernel only
	always_ff @(posedge iCLOCK or negedge inRESET) begin
		if (!inRESET) begin
			for (int i = 0; i < `LDST_PAGE_NUM; i++) begin
				flags[i] <= '0;
			end
		end
		else if (cfg_we) begin
			flags[cfg_page] <= cfg_flags;
		end
	end

	// Registered lookup, flags valid the cycle after lookup_en
	always_ff @(posedge iCLOCK or negedge inRESET) begin
		if (!inRESET) begin
			lookup_flags <= '0;
		end
		else if (lookup_en) begin
			lookup_flags <= flags[lookup_page];
		end
	end

	// Reconfiguring a page while it is looked up gives undefined flags
	a_no_cfg_lookup_clash: assert property (
		@(posedge iCLOCK) disable iff (!inRESET)
		(cfg_we && lookup_en) |-> (cfg_page != lookup_page)
	);

endmodule

`default_nettype wire

// ==== logic/mmu_prot_pkg.sv ====
package mmu_prot_pkg;

	// Privilege field of the MMU flag word
	typedef enum logic [1:0] {
		PRIV_KERNEL_ONLY       = 2'd0,
		PRIV_ALL_RO            = 2'd1,
		PRIV_KERNEL_RW_USER_RO = 2'd2,
		PRIV_ALL_RW            = 2'd3
	} priv_field_t;

	// Exception numbers reported on the response channel
	typedef enum logic [6:0] {
		EXC_NONE      = 7'h00,
		EXC_PRIVILEGE = 7'h08
	} except_num_t;

endpackage

// ==== logic/exec_types_pkg.sv ====
package exec_types_pkg;

	// Load/store execute controller states
	typedef enum logic [1:0] {
		EXEC_IDLE   = 2'd0,
		EXEC_LOOKUP = 2'd1,
		EXEC_ACCESS = 2'd2,
		EXEC_RESP   = 2'd3
	} exec_state_t;

	// Direction of the memory access
	typedef enum logic {
		LDST_OP_LOAD  = 1'b0,
		LDST_OP_STORE = 1'b1
	} ldst_op_t;

endpackage

// ==== logic/ldst_defines.svh ====
`ifndef LDST_DEFINES_SVH
`define LDST_DEFINES_SVH

// Byte address and data word widths
`define LDST_ADDR_W 16
`define LDST_DATA_W 32

// Page index comes from the top address bits, 4 KB per page
`define LDST_PAGE_BITS 4
`define LDST_PAGE_NUM (1 << `LDST_PAGE_BITS)

// Word index into the data RAM, above the 2-bit byte offset
`define LDST_RAM_AW 8
`define LDST_RAM_DEPTH (1 << `LDST_RAM_AW)

// MMU flag word layout
`define MMU_FLAG_W 12
`define MMU_PRIV_LSB 4

`endif
